//--- verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // ==========================================================
  // Data path widths
  // ==========================================================

  // One data or address word
  typedef logic [31:0] word_t;

  // Byte-lane write strobes, one bit per byte of a word
  typedef logic [3:0] strb_t;

  // Load/store funct3 field
  typedef logic [2:0] funct3_t;

  // Register file index
  typedef logic [4:0] reg_addr_t;

  // ==========================================================
  // Load/store size encodings (RV32I funct3)
  // ==========================================================

  // Signed variants, shared by loads and stores
  localparam funct3_t F3_B  = 3'b000;
  localparam funct3_t F3_H  = 3'b001;
  localparam funct3_t F3_W  = 3'b010;

  // Zero-extended loads only
  localparam funct3_t F3_BU = 3'b100;
  localparam funct3_t F3_HU = 3'b101;

  // ==========================================================
  // Result source select
  // ==========================================================

  typedef logic [2:0] res_src_t;

  localparam res_src_t RES_ALU = 3'b000;
  localparam res_src_t RES_MEM = 3'b001;
  // Link address for JAL/JALR
  localparam res_src_t RES_PC4 = 3'b010;
  // Target adder output, used by AUIPC
  localparam res_src_t RES_TGT = 3'b011;
  localparam res_src_t RES_M   = 3'b100;

  // ==========================================================
  // Trap causes
  // ==========================================================

  typedef logic [1:0] trap_code_t;

  localparam trap_code_t TRAP_LDST_MISALIGN = 2'b10;

endpackage

`default_nettype wire

//--- verilog/mem_access_decode.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_decode (
  input  wire logic            instr_valid_i,
  input  wire logic            stall_i,
  input  wire logic            mem_read_i,
  input  wire logic            mem_write_i,
  input  wire logic            trap_i,
  input  wire mem_pkg::funct3_t funct3_i,
  input  wire mem_pkg::word_t  addr_i,
  input  wire mem_pkg::word_t  rs2_data_i,
  output logic                 dmem_ren_o,
  output logic                 dmem_we_o,
  output mem_pkg::word_t       dmem_addr_o,
  output mem_pkg::word_t       dmem_wdata_o,
  output mem_pkg::strb_t       dmem_wstrb_o,
  output logic                 misalign_o,
  output logic                 trap_o
);

  // ==========================================================
  // Misalignment check
  // ==========================================================

  logic misalign;
  logic req_en;

  // Bytes never misalign, halfwords need bit 0 clear, words need both
  always_comb begin
    misalign = 1'b0;
    if (mem_read_i || mem_write_i) begin
      case (funct3_i)
        mem_pkg::F3_H,
        mem_pkg::F3_HU: misalign = addr_i[0];
        mem_pkg::F3_W:  misalign = |addr_i[1:0];
        default:        misalign = 1'b0;
      endcase
    end
  end

  assign misalign_o = misalign;

  // Upstream trap merged with the local one
  assign trap_o = trap_i || misalign;

  // ==========================================================
  // Memory port
  // ==========================================================

  // No new access while stalled or on a trapping instruction
  assign req_en = instr_valid_i && !stall_i && !trap_o;

  assign dmem_ren_o = req_en && mem_read_i;
  assign dmem_we_o  = req_en && mem_write_i;

  // SRAM is word addressed, lanes pick the bytes
  assign dmem_addr_o = {addr_i[31:2], 2'b00};

  // ==========================================================
  // Store lane formatting
  // ==========================================================

  // Replicate narrow data so every lane holds it
  always_comb begin
    case (funct3_i)
      mem_pkg::F3_B: dmem_wdata_o = {4{rs2_data_i[7:0]}};
      mem_pkg::F3_H: dmem_wdata_o = {2{rs2_data_i[15:0]}};
      default:       dmem_wdata_o = rs2_data_i;
    endcase
  end

  // Strobe selects the lanes actually written
  always_comb begin
    dmem_wstrb_o = 4'b0000;
    if (mem_write_i) begin
      case (funct3_i)
        mem_pkg::F3_B: dmem_wstrb_o = 4'b0001 << addr_i[1:0];
        // Upper or lower halfword
        mem_pkg::F3_H: dmem_wstrb_o = addr_i[1] ? 4'b1100 : 4'b0011;
        default:       dmem_wstrb_o = 4'b1111;
      endcase
    end
  end

  // ==========================================================
  // Checks
  // ==========================================================

  // A single instruction is never both a load and a store
  always_comb begin
    a_ren_we_excl : assert (!(dmem_ren_o && dmem_we_o))
      else $error("dmem read and write enabled together");
  end

endmodule

`default_nettype wire

//--- verilog/mem_load_align.sv
`timescale 1ns/1ps
`default_nettype none

module mem_load_align (
  input  wire mem_pkg::word_t   rdata_i,
  input  wire logic [1:0]       addr_lo_i,
  input  wire mem_pkg::funct3_t funct3_i,
  output mem_pkg::word_t        ld_data_o
);

  // ==========================================================
  // Lane selection
  // ==========================================================

  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  // Byte offset picks one of four lanes
  assign ld_byte = rdata_i[{addr_lo_i, 3'b000} +: 8];

  // Only bit 1 matters here, bit 0 is a misalignment
  assign ld_half = rdata_i[{addr_lo_i[1], 4'b0000} +: 16];

  // ==========================================================
  // Extension
  // ==========================================================

  always_comb begin
    case (funct3_i)
      // Signed byte
      mem_pkg::F3_B: begin
        ld_data_o = {{24{ld_byte[7]}}, ld_byte};
      end
      // Signed halfword
      mem_pkg::F3_H: begin
        ld_data_o = {{16{ld_half[15]}}, ld_half};
      end
      mem_pkg::F3_BU: begin
        ld_data_o = {24'h000000, ld_byte};
      end
      mem_pkg::F3_HU: begin
        ld_data_o = {16'h0000, ld_half};
      end
      mem_pkg::F3_W: begin
        ld_data_o = rdata_i;
      end
      // Reserved codes, raw word
      default: begin
        ld_data_o = rdata_i;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/mem_redirect.sv
`timescale 1ns/1ps
`default_nettype none

module mem_redirect #(
  parameter int BPRED = 0
) (
  input  wire logic           instr_valid_i,
  input  wire logic           is_branch_i,
  input  wire logic           branch_taken_i,
  input  wire logic           is_jalr_i,
  input  wire logic           bpred_taken_i,
  input  wire mem_pkg::word_t jb_tgt_i,
  input  wire mem_pkg::word_t pred_tgt_i,
  input  wire mem_pkg::word_t pc_plus4_i,
  output logic                redir_valid_o,
  output mem_pkg::word_t      redir_tgt_o
);

  localparam bit PRED_ON = (BPRED != 0);

  logic br_pred_taken;
  logic br_mispred;
  logic jalr_mispred;

  // ==========================================================
  // Misprediction detection
  // ==========================================================

  // Static not-taken without a predictor
  assign br_pred_taken = PRED_ON && bpred_taken_i;

  assign br_mispred = is_branch_i && (branch_taken_i != br_pred_taken);

  // Without a predictor every JALR fetched the wrong path
  // With one, both direction and target have to agree
  assign jalr_mispred = is_jalr_i &&
                        (!PRED_ON || !bpred_taken_i || (pred_tgt_i != jb_tgt_i));

  // ==========================================================
  // Redirect
  // ==========================================================

  assign redir_valid_o = instr_valid_i && (br_mispred || jalr_mispred);

  // Falsely taken branch resumes at the fall-through PC
  assign redir_tgt_o = (br_mispred && !branch_taken_i) ? pc_plus4_i : jb_tgt_i;

  // A resolving instruction is never both a branch and a JALR
  always_comb begin
    a_br_jalr_excl : assert (!(instr_valid_i && is_branch_i && is_jalr_i))
      else $error("branch and JALR resolved together");
  end

endmodule

`default_nettype wire

//--- verilog/mem_result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_result_stage (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                stall_i,
  input  wire logic                instr_valid_i,
  input  wire logic                reg_write_i,
  input  wire logic                trap_i,
  input  wire logic                misalign_i,
  input  wire mem_pkg::trap_code_t trap_code_i,
  input  wire mem_pkg::res_src_t   res_src_i,
  input  wire mem_pkg::reg_addr_t  rd_i,
  input  wire mem_pkg::word_t      alu_result_i,
  input  wire mem_pkg::word_t      pc_plus4_i,
  input  wire mem_pkg::word_t      jb_tgt_i,
  input  wire mem_pkg::word_t      m_result_i,
  input  wire mem_pkg::word_t      ld_data_i,
  output mem_pkg::word_t           result_mem_o,
  output logic                     instr_valid_wb_o,
  output logic                     reg_write_wb_o,
  output logic                     trap_wb_o,
  output mem_pkg::trap_code_t      trap_code_wb_o,
  output mem_pkg::res_src_t        res_src_wb_o,
  output mem_pkg::reg_addr_t       rd_wb_o,
  output mem_pkg::word_t           alu_result_wb_o,
  output mem_pkg::word_t           pc_plus4_wb_o,
  output mem_pkg::word_t           jb_tgt_wb_o,
  output mem_pkg::word_t           m_result_wb_o,
  output mem_pkg::word_t           ld_data_wb_o
);

  // ==========================================================
  // Forwarding result
  // ==========================================================

  // Load data is forwarded separately, so RES_MEM falls to default
  always_comb begin
    case (res_src_i)
      mem_pkg::RES_M:   result_mem_o = m_result_i;
      mem_pkg::RES_PC4: result_mem_o = pc_plus4_i;
      mem_pkg::RES_TGT: result_mem_o = jb_tgt_i;
      default:          result_mem_o = alu_result_i;
    endcase
  end

  // ==========================================================
  // MEM/WB register, control part
  // ==========================================================

  logic advance;

  // Register moves only on unstalled edges
  assign advance = !stall_i;

  // Cleared on a bubble so WB can act on these directly
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      instr_valid_wb_o <= 1'b0;
      reg_write_wb_o   <= 1'b0;
      trap_wb_o        <= 1'b0;
    end else if (advance) begin
      instr_valid_wb_o <= instr_valid_i;
      // Trapping instruction must not retire a write
      reg_write_wb_o   <= instr_valid_i && reg_write_i && !trap_i;
      trap_wb_o        <= instr_valid_i && trap_i;
    end
  end

  // ==========================================================
  // MEM/WB register, payload part
  // ==========================================================

  // Captured even on bubbles, qualified by the control bits above
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      trap_code_wb_o  <= '0;
      res_src_wb_o    <= '0;
      rd_wb_o         <= '0;
      alu_result_wb_o <= '0;
      pc_plus4_wb_o   <= '0;
      jb_tgt_wb_o     <= '0;
      m_result_wb_o   <= '0;
      ld_data_wb_o    <= '0;
    end else if (advance) begin
      // Local misalignment overrides the upstream cause
      trap_code_wb_o  <= misalign_i ? mem_pkg::TRAP_LDST_MISALIGN : trap_code_i;
      res_src_wb_o    <= res_src_i;
      rd_wb_o         <= rd_i;
      alu_result_wb_o <= alu_result_i;
      pc_plus4_wb_o   <= pc_plus4_i;
      jb_tgt_wb_o     <= jb_tgt_i;
      m_result_wb_o   <= m_result_i;
      ld_data_wb_o    <= ld_data_i;
    end
  end

  // ==========================================================
  // Checks
  // ==========================================================

  // An instruction in WB is not lost while the pipe is frozen
  a_wb_hold_on_stall : assert property (
    @(posedge clk) disable iff (!rst_n)
    (stall_i && instr_valid_wb_o) |=> instr_valid_wb_o
  ) else $error("WB instruction dropped during stall");

endmodule

`default_nettype wire

//--- verilog/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
  parameter int BPRED = 1
) (
  input  wire logic                clk,
  input  wire logic                rst_n,

  // Flow control from the hazard unit
  input  wire logic                stall_i,
  input  wire logic                instr_valid_i,

  // Control and operands from EX/MEM
  input  wire logic                reg_write_i,
  input  wire logic                mem_read_i,
  input  wire logic                mem_write_i,
  input  wire logic                trap_i,
  input  wire mem_pkg::trap_code_t trap_code_i,
  input  wire mem_pkg::res_src_t   res_src_i,
  input  wire mem_pkg::reg_addr_t  rd_i,
  input  wire mem_pkg::funct3_t    funct3_i,
  input  wire mem_pkg::word_t      alu_result_i,
  input  wire mem_pkg::word_t      rs2_data_i,
  input  wire mem_pkg::word_t      pc_plus4_i,
  input  wire mem_pkg::word_t      jb_tgt_i,
  input  wire mem_pkg::word_t      m_result_i,

  // Control flow resolution
  input  wire logic                is_branch_i,
  input  wire logic                branch_taken_i,
  input  wire logic                is_jalr_i,
  input  wire logic                bpred_taken_i,
  input  wire mem_pkg::word_t      pred_tgt_i,

  // Data memory, combinational read
  output logic                     dmem_ren_o,
  output logic                     dmem_we_o,
  output mem_pkg::word_t           dmem_addr_o,
  output mem_pkg::word_t           dmem_wdata_o,
  output mem_pkg::strb_t           dmem_wstrb_o,
  input  wire mem_pkg::word_t      dmem_rdata_i,

  // Forwarding
  output mem_pkg::word_t           ld_data_mem_o,
  output mem_pkg::word_t           result_mem_o,

  // Fetch redirect
  output logic                     redir_valid_o,
  output mem_pkg::word_t           redir_tgt_o,

  // To WB
  output logic                     instr_valid_wb_o,
  output logic                     reg_write_wb_o,
  output logic                     trap_wb_o,
  output mem_pkg::trap_code_t      trap_code_wb_o,
  output mem_pkg::res_src_t        res_src_wb_o,
  output mem_pkg::reg_addr_t       rd_wb_o,
  output mem_pkg::word_t           alu_result_wb_o,
  output mem_pkg::word_t           pc_plus4_wb_o,
  output mem_pkg::word_t           jb_tgt_wb_o,
  output mem_pkg::word_t           m_result_wb_o,
  output mem_pkg::word_t           ld_data_wb_o
);

  logic           mem_misalign;
  logic           trap_any;
  mem_pkg::word_t ld_data;

  // ==========================================================
  // Access decode and memory port
  // ==========================================================

  // ALU result is the effective address
  mem_access_decode u_decode (
    .instr_valid_i (instr_valid_i),
    .stall_i       (stall_i),
    .mem_read_i    (mem_read_i),
    .mem_write_i   (mem_write_i),
    .trap_i        (trap_i),
    .funct3_i      (funct3_i),
    .addr_i        (alu_result_i),
    .rs2_data_i    (rs2_data_i),
    .dmem_ren_o    (dmem_ren_o),
    .dmem_we_o     (dmem_we_o),
    .dmem_addr_o   (dmem_addr_o),
    .dmem_wdata_o  (dmem_wdata_o),
    .dmem_wstrb_o  (dmem_wstrb_o),
    .misalign_o    (mem_misalign),
    .trap_o        (trap_any)
  );

  // ==========================================================
  // Load formatting
  // ==========================================================

  mem_load_align u_load_align (
    .rdata_i   (dmem_rdata_i),
    .addr_lo_i (alu_result_i[1:0]),
    .funct3_i  (funct3_i),
    .ld_data_o (ld_data)
  );

  // SRAM data is ready this cycle, so loads forward from MEM
  assign ld_data_mem_o = ld_data;

  // ==========================================================
  // Branch and JALR resolution
  // ==========================================================

  mem_redirect #(
    .BPRED (BPRED)
  ) u_redirect (
    .instr_valid_i  (instr_valid_i),
    .is_branch_i    (is_branch_i),
    .branch_taken_i (branch_taken_i),
    .is_jalr_i      (is_jalr_i),
    .bpred_taken_i  (bpred_taken_i),
    .jb_tgt_i       (jb_tgt_i),
    .pred_tgt_i     (pred_tgt_i),
    .pc_plus4_i     (pc_plus4_i),
    .redir_valid_o  (redir_valid_o),
    .redir_tgt_o    (redir_tgt_o)
  );

  // ==========================================================
  // Forwarding mux and MEM/WB register
  // ==========================================================

  // Merged trap feeds the WB trap flag
  mem_result_stage u_result (
    .clk              (clk),
    .rst_n            (rst_n),
    .stall_i          (stall_i),
    .instr_valid_i    (instr_valid_i),
    .reg_write_i      (reg_write_i),
    .trap_i           (trap_any),
    .misalign_i       (mem_misalign),
    .trap_code_i      (trap_code_i),
    .res_src_i        (res_src_i),
    .rd_i             (rd_i),
    .alu_result_i     (alu_result_i),
    .pc_plus4_i       (pc_plus4_i),
    .jb_tgt_i         (jb_tgt_i),
    .m_result_i       (m_result_i),
    .ld_data_i        (ld_data),
    .result_mem_o     (result_mem_o),
    .instr_valid_wb_o (instr_valid_wb_o),
    .reg_write_wb_o   (reg_write_wb_o),
    .trap_wb_o        (trap_wb_o),
    .trap_code_wb_o   (trap_code_wb_o),
    .res_src_wb_o     (res_src_wb_o),
    .rd_wb_o          (rd_wb_o),
    .alu_result_wb_o  (alu_result_wb_o),
    .pc_plus4_wb_o    (pc_plus4_wb_o),
    .jb_tgt_wb_o      (jb_tgt_wb_o),
    .m_result_wb_o    (m_result_wb_o),
    .ld_data_wb_o     (ld_data_wb_o)
  );

endmodule

`default_nettype wire

//--- bench/tb_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

  localparam int WAIT_LIMIT = 16;

  // ==========================================================
  // DUT signals
  // ==========================================================

  logic                clk;
  logic                rst_n;
  logic                stall_i;
  logic                instr_valid_i;
  logic                reg_write_i;
  logic                mem_read_i;
  logic                mem_write_i;
  logic                trap_i;
  mem_pkg::trap_code_t trap_code_i;
  mem_pkg::res_src_t   res_src_i;
  mem_pkg::reg_addr_t  rd_i;
  mem_pkg::funct3_t    funct3_i;
  mem_pkg::word_t      alu_result_i;
  mem_pkg::word_t      rs2_data_i;
  mem_pkg::word_t      pc_plus4_i;
  mem_pkg::word_t      jb_tgt_i;
  mem_pkg::word_t      m_result_i;
  logic                is_branch_i;
  logic                branch_taken_i;
  logic                is_jalr_i;
  logic                bpred_taken_i;
  mem_pkg::word_t      pred_tgt_i;
  mem_pkg::word_t      dmem_rdata_i;
  logic                dmem_ren_o;
  logic                dmem_we_o;
  mem_pkg::word_t      dmem_addr_o;
  mem_pkg::word_t      dmem_wdata_o;
  mem_pkg::strb_t      dmem_wstrb_o;
  mem_pkg::word_t      ld_data_mem_o;
  mem_pkg::word_t      result_mem_o;
  logic                redir_valid_o;
  mem_pkg::word_t      redir_tgt_o;
  logic                instr_valid_wb_o;
  logic                reg_write_wb_o;
  logic                trap_wb_o;
  mem_pkg::trap_code_t trap_code_wb_o;
  mem_pkg::res_src_t   res_src_wb_o;
  mem_pkg::reg_addr_t  rd_wb_o;
  mem_pkg::word_t      alu_result_wb_o;
  mem_pkg::word_t      pc_plus4_wb_o;
  mem_pkg::word_t      jb_tgt_wb_o;
  mem_pkg::word_t      m_result_wb_o;
  mem_pkg::word_t      ld_data_wb_o;

  logic [31:0] lfsr = 32'ha4b2e923;
  int          errors = 0;
  int          checks = 0;
  int          timeouts = 0;

  mem_stage #(.BPRED(1)) dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ==========================================================
  // Helpers
  // ==========================================================

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic check(input mem_pkg::word_t got, input mem_pkg::word_t want,
                       input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, want);
    end
  endtask

  // Idle bus, no stall
  task automatic clear_inputs();
    stall_i        <= 1'b0;
    instr_valid_i  <= 1'b0;
    reg_write_i    <= 1'b0;
    mem_read_i     <= 1'b0;
    mem_write_i    <= 1'b0;
    trap_i         <= 1'b0;
    trap_code_i    <= '0;
    res_src_i      <= '0;
    rd_i           <= '0;
    funct3_i       <= '0;
    alu_result_i   <= '0;
    rs2_data_i     <= '0;
    pc_plus4_i     <= '0;
    jb_tgt_i       <= '0;
    m_result_i     <= '0;
    is_branch_i    <= 1'b0;
    branch_taken_i <= 1'b0;
    is_jalr_i      <= 1'b0;
    bpred_taken_i  <= 1'b0;
    pred_tgt_i     <= '0;
    dmem_rdata_i   <= '0;
  endtask

  // Idles the inputs each edge until WB valid reaches the wanted level
  task automatic wait_wb(input logic want, output int edges);
    edges = 0;
    while (instr_valid_wb_o !== want && edges < WAIT_LIMIT) begin
      @(posedge clk);
      clear_inputs();
      @(negedge clk);
      edges++;
    end
    if (instr_valid_wb_o !== want) begin
      timeouts++;
      $display("Timeout at %0t: instr_valid_wb_o never became %0b", $time, want);
    end
  endtask

  task automatic drain_pipe();
    int edges;
    @(posedge clk);
    clear_inputs();
    wait_wb(1'b0, edges);
  endtask

  // ==========================================================
  // Expected values from the access rules
  // ==========================================================

  function automatic int access_size(input mem_pkg::funct3_t f3);
    case (f3)
      mem_pkg::F3_B, mem_pkg::F3_BU: return 1;
      mem_pkg::F3_H, mem_pkg::F3_HU: return 2;
      default:                       return 4;
    endcase
  endfunction

  // Lanes from the offset up to the access size
  function automatic mem_pkg::strb_t strobe_expected(input mem_pkg::funct3_t f3,
                                                     input int off);
    mem_pkg::strb_t s;
    s = '0;
    for (int lane = 0; lane < 4; lane++) begin
      if (lane >= off && lane < off + access_size(f3)) begin
        s[lane] = 1'b1;
      end
    end
    return s;
  endfunction

  function automatic mem_pkg::word_t wdata_expected(input mem_pkg::funct3_t f3,
                                                    input mem_pkg::word_t d);
    case (access_size(f3))
      1:       return {4{d[7:0]}};
      2:       return {2{d[15:0]}};
      default: return d;
    endcase
  endfunction

  function automatic mem_pkg::word_t load_expected(input mem_pkg::funct3_t f3,
                                                   input int off,
                                                   input mem_pkg::word_t w);
    mem_pkg::word_t lane;
    lane = w >> (8 * off);
    case (f3)
      mem_pkg::F3_B:  return {{24{lane[7]}}, lane[7:0]};
      mem_pkg::F3_BU: return {24'd0, lane[7:0]};
      mem_pkg::F3_H:  return {{16{lane[15]}}, lane[15:0]};
      mem_pkg::F3_HU: return {16'd0, lane[15:0]};
      default:        return w;
    endcase
  endfunction

  // ==========================================================
  // Directed tests
  // ==========================================================

  task automatic reset_values();
    check(32'(instr_valid_wb_o), 32'd0, "instr_valid_wb after reset");
    check(32'(reg_write_wb_o), 32'd0, "reg_write_wb after reset");
    check(32'(trap_wb_o), 32'd0, "trap_wb after reset");
    check(alu_result_wb_o, 32'd0, "alu_result_wb after reset");
    // Read then write requested without a valid instruction
    @(posedge clk);
    clear_inputs();
    mem_read_i <= 1'b1;
    @(negedge clk);
    check(32'(dmem_ren_o), 32'd0, "ren with no valid instruction");
    @(posedge clk);
    clear_inputs();
    mem_write_i <= 1'b1;
    @(negedge clk);
    check(32'(dmem_we_o), 32'd0, "we with no valid instruction");
  endtask

  task automatic store_lanes();
    mem_pkg::funct3_t f3s [3] = '{mem_pkg::F3_B, mem_pkg::F3_H, mem_pkg::F3_W};
    mem_pkg::word_t   addr;
    mem_pkg::word_t   data;
    for (int i = 0; i < 3; i++) begin
      for (int off = 0; off < 4; off += access_size(f3s[i])) begin
        addr = rand_bits(30) << 2;
        addr[1:0] = 2'(off);
        data = rand_bits(32);
        @(posedge clk);
        clear_inputs();
        instr_valid_i <= 1'b1;
        mem_write_i   <= 1'b1;
        funct3_i      <= f3s[i];
        alu_result_i  <= addr;
        rs2_data_i    <= data;
        @(negedge clk);
        check(32'(dmem_we_o), 32'd1, $sformatf("store f%0d off %0d we", i, off));
        check(32'(dmem_ren_o), 32'd0, $sformatf("store f%0d off %0d ren", i, off));
        check(dmem_addr_o, {addr[31:2], 2'b00}, $sformatf("store f%0d off %0d addr", i, off));
        check(dmem_wdata_o, wdata_expected(f3s[i], data),
              $sformatf("store f%0d off %0d wdata", i, off));
        check(32'(dmem_wstrb_o), 32'(strobe_expected(f3s[i], off)),
              $sformatf("store f%0d off %0d wstrb", i, off));
        // Same store frozen by a stall
        @(posedge clk);
        stall_i <= 1'b1;
        @(negedge clk);
        check(32'(dmem_we_o), 32'd0, $sformatf("store f%0d off %0d we stalled", i, off));
      end
    end
  endtask

  task automatic load_extension();
    mem_pkg::funct3_t f3s [5] = '{mem_pkg::F3_B, mem_pkg::F3_H, mem_pkg::F3_W,
                                  mem_pkg::F3_BU, mem_pkg::F3_HU};
    mem_pkg::word_t   addr;
    mem_pkg::word_t   rdata;
    mem_pkg::word_t   want_ld;
    int               edges;
    for (int i = 0; i < 5; i++) begin
      for (int off = 0; off < 4; off += access_size(f3s[i])) begin
        addr = rand_bits(30) << 2;
        addr[1:0] = 2'(off);
        rdata = rand_bits(32);
        want_ld = load_expected(f3s[i], off, rdata);
        @(posedge clk);
        clear_inputs();
        instr_valid_i <= 1'b1;
        reg_write_i   <= 1'b1;
        mem_read_i    <= 1'b1;
        funct3_i      <= f3s[i];
        alu_result_i  <= addr;
        dmem_rdata_i  <= rdata;
        @(negedge clk);
        check(32'(dmem_ren_o), 32'd1, $sformatf("load %0d off %0d ren", i, off));
        check(ld_data_mem_o, want_ld, $sformatf("load %0d off %0d ld_data_mem", i, off));
        wait_wb(1'b1, edges);
        check(edges, 1, "load WB latency");
        check(ld_data_wb_o, want_ld, $sformatf("load %0d off %0d ld_data_wb", i, off));
      end
    end
  endtask

  task automatic misaligned_access(input logic is_load, input mem_pkg::funct3_t f3,
                                   input int off);
    mem_pkg::word_t addr;
    int             edges;
    addr = rand_bits(30) << 2;
    addr[1:0] = 2'(off);
    @(posedge clk);
    clear_inputs();
    instr_valid_i <= 1'b1;
    reg_write_i   <= is_load;
    mem_read_i    <= is_load;
    mem_write_i   <= !is_load;
    funct3_i      <= f3;
    alu_result_i  <= addr;
    rs2_data_i    <= rand_bits(32);
    @(negedge clk);
    check(32'(dmem_ren_o), 32'd0, "misaligned ren");
    check(32'(dmem_we_o), 32'd0, "misaligned we");
    wait_wb(1'b1, edges);
    check(edges, 1, "misaligned WB latency");
    check(32'(trap_wb_o), 32'd1, "misaligned trap_wb");
    check(32'(trap_code_wb_o), 32'(mem_pkg::TRAP_LDST_MISALIGN), "misaligned trap_code_wb");
    check(32'(reg_write_wb_o), 32'd0, "misaligned reg_write_wb");
  endtask

  task automatic result_pipeline();
    mem_pkg::res_src_t  srcs [5] = '{mem_pkg::RES_ALU, mem_pkg::RES_MEM, mem_pkg::RES_PC4,
                                     mem_pkg::RES_TGT, mem_pkg::RES_M};
    mem_pkg::word_t     alu, pc4, tgt, mres, rdata, want;
    mem_pkg::reg_addr_t rd;
    int                 edges;
    // Forwarding mux, one pass per result source
    for (int i = 0; i < 5; i++) begin
      alu = rand_bits(32);
      pc4 = rand_bits(32);
      tgt = rand_bits(32);
      mres = rand_bits(32);
      want = (srcs[i] == mem_pkg::RES_M)   ? mres :
             (srcs[i] == mem_pkg::RES_PC4) ? pc4  :
             (srcs[i] == mem_pkg::RES_TGT) ? tgt  : alu;
      @(posedge clk);
      clear_inputs();
      instr_valid_i <= 1'b1;
      res_src_i     <= srcs[i];
      alu_result_i  <= alu;
      pc_plus4_i    <= pc4;
      jb_tgt_i      <= tgt;
      m_result_i    <= mres;
      @(negedge clk);
      check(result_mem_o, want, $sformatf("result_mem res_src %0d", srcs[i]));
    end
    // Capture, then three stalled edges with new inputs behind
    rd = 5'(rand_bits(5));
    rdata = rand_bits(32);
    @(posedge clk);
    clear_inputs();
    instr_valid_i <= 1'b1;
    reg_write_i   <= 1'b1;
    rd_i          <= rd;
    res_src_i     <= mem_pkg::RES_PC4;
    trap_code_i   <= 2'b01;
    funct3_i      <= mem_pkg::F3_W;
    alu_result_i  <= alu;
    pc_plus4_i    <= pc4;
    jb_tgt_i      <= tgt;
    m_result_i    <= mres;
    dmem_rdata_i  <= rdata;
    @(posedge clk);
    stall_i      <= 1'b1;
    rd_i         <= ~rd;
    alu_result_i <= rand_bits(32);
    pc_plus4_i   <= rand_bits(32);
    m_result_i   <= rand_bits(32);
    dmem_rdata_i <= rand_bits(32);
    for (int n = 0; n < 4; n++) begin
      @(negedge clk);
      check(32'(instr_valid_wb_o), 32'd1, $sformatf("valid_wb edge %0d", n));
      check(32'(reg_write_wb_o), 32'd1, $sformatf("reg_write_wb edge %0d", n));
      check(32'(rd_wb_o), 32'(rd), $sformatf("rd_wb edge %0d", n));
      check(32'(res_src_wb_o), 32'(mem_pkg::RES_PC4), $sformatf("res_src_wb edge %0d", n));
      check(32'(trap_code_wb_o), 32'd1, $sformatf("trap_code_wb edge %0d", n));
      check(alu_result_wb_o, alu, $sformatf("alu_result_wb edge %0d", n));
      check(pc_plus4_wb_o, pc4, $sformatf("pc_plus4_wb edge %0d", n));
      check(jb_tgt_wb_o, tgt, $sformatf("jb_tgt_wb edge %0d", n));
      check(m_result_wb_o, mres, $sformatf("m_result_wb edge %0d", n));
      check(ld_data_wb_o, rdata, $sformatf("ld_data_wb edge %0d", n));
    end
    // Bubble after the stall releases
    wait_wb(1'b0, edges);
    check(32'(reg_write_wb_o), 32'd0, "reg_write_wb after bubble");
  endtask

  task automatic branch_resolve(input logic br, input logic taken, input logic jalr,
                                input logic bp, input logic tgt_match, input string name);
    mem_pkg::word_t jb, pc4, ptgt, want_tgt;
    logic           want_valid;
    jb = rand_bits(32);
    pc4 = rand_bits(32);
    ptgt = tgt_match ? jb : jb ^ 32'h0000_0010;
    // Predictor on
    if (br) begin
      want_valid = (taken != bp);
      want_tgt = (bp && !taken) ? pc4 : jb;
    end else begin
      want_valid = jalr && (!bp || !tgt_match);
      want_tgt = jb;
    end
    @(posedge clk);
    clear_inputs();
    instr_valid_i  <= 1'b1;
    is_branch_i    <= br;
    branch_taken_i <= taken;
    is_jalr_i      <= jalr;
    bpred_taken_i  <= bp;
    jb_tgt_i       <= jb;
    pred_tgt_i     <= ptgt;
    pc_plus4_i     <= pc4;
    @(negedge clk);
    check(32'(redir_valid_o), 32'(want_valid), {name, " redir_valid"});
    if (want_valid) begin
      check(redir_tgt_o, want_tgt, {name, " redir_tgt"});
    end
  endtask

  task automatic redirect_cases();
    branch_resolve(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, "taken, predicted not-taken");
    branch_resolve(1'b1, 1'b0, 1'b0, 1'b1, 1'b1, "not-taken, predicted taken");
    branch_resolve(1'b1, 1'b1, 1'b0, 1'b1, 1'b1, "taken, predicted taken");
    branch_resolve(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, "not-taken, predicted not-taken");
    branch_resolve(1'b0, 1'b0, 1'b1, 1'b1, 1'b1, "JALR target hit");
    branch_resolve(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, "JALR target miss");
    branch_resolve(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, "JALR not predicted");
  endtask

  // ==========================================================
  // Main sequence
  // ==========================================================

  initial begin
    clear_inputs();
    rst_n <= 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    reset_values();
    drain_pipe();
    store_lanes();
    drain_pipe();
    load_extension();
    drain_pipe();
    misaligned_access(1'b1, mem_pkg::F3_H, 1);
    misaligned_access(1'b0, mem_pkg::F3_W, 2);
    drain_pipe();
    result_pipeline();
    drain_pipe();
    redirect_cases();
    $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
verilog/mem_pkg.sv
verilog/mem_access_decode.sv
verilog/mem_load_align.sv
verilog/mem_redirect.sv
verilog/mem_result_stage.sv
verilog/mem_stage.sv
bench/tb_mem_stage.sv

//--- run.sh
#!/bin/sh
# Build the MEM stage testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_mem_stage -f src.f -o sim_mem_stage \
  && ./obj_dir/sim_mem_stage > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
exit 0
